/* hw/radio_pkg.sv */
// Shared constants and types for the radio control plane and sample path
// All blocks run on the single bus_clk with one active-low async reset
// Setting addresses are 8 bits and readback indices 3 bits wide
package radio_pkg;

   ////////////////////
   // Widths and depths
   localparam int WORD_W       = 64;
   localparam int SAMPLE_W     = 32;   // Packed I/Q
   localparam int SET_ADDR_W   = 8;
   localparam int SET_DATA_W   = 32;
   localparam int RB_IDX_W     = 3;
   localparam int CTRL_DEPTH   = 4;    // Also the host's starting command credits
   localparam int RX_BUF_DEPTH = 8;
   localparam int OVF_W        = 16;
   localparam int CTRL_PTR_W   = $clog2(CTRL_DEPTH);
   localparam int RX_PTR_W     = $clog2(RX_BUF_DEPTH);
   localparam int CRED_W       = 16;   // Response and RX credit counters
   localparam int PKT_W        = 8;    // Packet length in words

   // Command word fields
   localparam int CMD_OP_LSB   = 56;
   localparam int CMD_ADDR_LSB = 48;

   ////////////////////
   // Setting bus addresses
   localparam logic [SET_ADDR_W-1:0] SR_LOOPBACK   = 8'd6;
   localparam logic [SET_ADDR_W-1:0] SR_TEST       = 8'd21;
   localparam logic [SET_ADDR_W-1:0] SR_CODEC_IDLE = 8'd22;
   localparam logic [SET_ADDR_W-1:0] SR_TX_CTRL    = 8'd64;   // Bit 0 run_tx
   localparam logic [SET_ADDR_W-1:0] SR_RX_CTRL    = 8'd96;   // Bit 0 run_rx, 15..8 length
   localparam logic [SET_ADDR_W-1:0] SR_TIME_HI    = 8'd128;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_LO    = 8'd129;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_CTRL  = 8'd130;  // Bit 0 load at pps

   ////////////////////
   // Readback indices
   localparam logic [RB_IDX_W-1:0] RB_TEST      = 3'd0;
   localparam logic [RB_IDX_W-1:0] RB_TIME      = 3'd1;
   localparam logic [RB_IDX_W-1:0] RB_TIME_PPS  = 3'd2;
   localparam logic [RB_IDX_W-1:0] RB_RADIO     = 3'd3;
   localparam logic [RB_IDX_W-1:0] RB_RX_STATUS = 3'd5;

   // Reply to an unknown opcode
   localparam logic [WORD_W-1:0] ERR_RESP = '1;

   typedef enum logic [7:0] {
      CMD_WRITE = 8'd1,
      CMD_READ  = 8'd2
   } cmd_op_e;

   typedef enum logic {
      RX_EMPTY,
      RX_HALF      // First sample of the pair held
   } rx_state_e;

endpackage

/* hw/ctrl_cmd_decoder.sv */
// Host command decoder with a small command FIFO
// The host must hold a command credit for every word it presents
// Exactly one response per command, sent only against a response credit
`timescale 1ns/1ps

module ctrl_cmd_decoder (
   input  logic                                 bus_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_ctrl_valid,
   input  logic [radio_pkg::WORD_W-1:0]         i_ctrl_data,
   input  logic                                 i_resp_credit,
   input  logic [radio_pkg::WORD_W-1:0]         i_rb_data,
   output logic                                 o_ctrl_credit,
   output logic                                 o_resp_valid,
   output logic [radio_pkg::WORD_W-1:0]         o_resp_data,
   output logic                                 o_set_stb,
   output logic [radio_pkg::SET_ADDR_W-1:0]     o_set_addr,
   output logic [radio_pkg::SET_DATA_W-1:0]     o_set_data,
   output logic [radio_pkg::RB_IDX_W-1:0]       o_rb_idx
);

   logic [radio_pkg::WORD_W-1:0]     fifo_mem [radio_pkg::CTRL_DEPTH];
   logic [radio_pkg::CTRL_PTR_W-1:0] wr_ptr;
   logic [radio_pkg::CTRL_PTR_W-1:0] rd_ptr;
   logic [radio_pkg::CTRL_PTR_W:0]   fifo_cnt;
   logic [radio_pkg::CRED_W-1:0]     resp_cred;
   logic [radio_pkg::WORD_W-1:0]     head;
   radio_pkg::cmd_op_e               head_op;
   logic                             pop;

   assign head     = fifo_mem[rd_ptr];
   assign head_op  = radio_pkg::cmd_op_e'(head[radio_pkg::CMD_OP_LSB +: 8]);
   assign pop      = (fifo_cnt != '0) && (resp_cred != '0);
   assign o_rb_idx = head[radio_pkg::CMD_ADDR_LSB +: radio_pkg::RB_IDX_W];  // Read index

   always_ff @(posedge bus_clk) begin
      if (i_ctrl_valid) fifo_mem[wr_ptr] <= i_ctrl_data;
   end

   ////////////////////
   // FIFO pointers and response credits
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fifo_cnt  <= '0;
         resp_cred <= '0;
      end else begin
         if (i_ctrl_valid) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (i_ctrl_valid && !pop) fifo_cnt <= fifo_cnt + 1'b1;
         else if (!i_ctrl_valid && pop) fifo_cnt <= fifo_cnt - 1'b1;
         if (i_resp_credit && !pop) resp_cred <= resp_cred + 1'b1;
         else if (!i_resp_credit && pop) resp_cred <= resp_cred - 1'b1;
      end
   end

   ////////////////////
   // Response and setting bus one cycle after the pop
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ctrl_credit <= 1'b0;
         o_resp_valid  <= 1'b0;
         o_set_stb     <= 1'b0;
      end else begin
         o_ctrl_credit <= pop;                // Freed FIFO slot
         o_resp_valid  <= pop;
         o_set_stb     <= pop && (head_op == radio_pkg::CMD_WRITE);
      end
   end

   always_ff @(posedge bus_clk) begin
      if (pop) begin
         o_set_addr <= head[radio_pkg::CMD_ADDR_LSB +: radio_pkg::SET_ADDR_W];
         o_set_data <= head[radio_pkg::SET_DATA_W-1:0];
         case (head_op)
            radio_pkg::CMD_WRITE: o_resp_data <= head;        // Echo
            radio_pkg::CMD_READ:  o_resp_data <= i_rb_data;   // Sampled now
            default:              o_resp_data <= radio_pkg::ERR_RESP;
         endcase
      end
   end

endmodule

/* hw/radio_settings.sv */
// Setting registers on the setting bus, plus the readback mux
// All registers clear on reset; a zero packet length reads as one word
// Readback is combinational from the index in the read command
`timescale 1ns/1ps

module radio_settings (
   input  logic                                 bus_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0]     i_set_addr,
   input  logic [radio_pkg::SET_DATA_W-1:0]     i_set_data,
   input  logic [radio_pkg::RB_IDX_W-1:0]       i_rb_idx,
   input  logic [radio_pkg::WORD_W-1:0]         i_vita_time,
   input  logic [radio_pkg::WORD_W-1:0]         i_vita_time_pps,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_tx,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_rx,
   input  logic [radio_pkg::OVF_W-1:0]          i_ovf_count,
   input  radio_pkg::rx_state_e                 i_rx_state,
   output logic [radio_pkg::WORD_W-1:0]         o_rb_data,
   output logic                                 o_loopback,
   output logic                                 o_run_tx,
   output logic                                 o_run_rx,
   output logic [radio_pkg::SAMPLE_W-1:0]       o_tx_idle,
   output logic [radio_pkg::PKT_W-1:0]          o_pkt_words
);

   logic [radio_pkg::SET_DATA_W-1:0] test_reg;
   logic [radio_pkg::PKT_W-1:0]      pkt_len;

   assign o_pkt_words = (pkt_len == '0) ? 8'd1 : pkt_len;

   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_loopback <= 1'b0;
         test_reg   <= '0;
         o_tx_idle  <= '0;
         o_run_tx   <= 1'b0;
         o_run_rx   <= 1'b0;
         pkt_len    <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            radio_pkg::SR_LOOPBACK:   o_loopback <= i_set_data[0];
            radio_pkg::SR_TEST:       test_reg   <= i_set_data;
            radio_pkg::SR_CODEC_IDLE: o_tx_idle  <= i_set_data;
            radio_pkg::SR_TX_CTRL:    o_run_tx   <= i_set_data[0];
            radio_pkg::SR_RX_CTRL: begin
               o_run_rx <= i_set_data[0];
               pkt_len  <= i_set_data[15:8];
            end
            default: ;                        // Time registers live in timekeeper
         endcase
      end
   end

   ////////////////////
   // Readback mux
   always_comb begin
      case (i_rb_idx)
         radio_pkg::RB_TEST:      o_rb_data = {32'd0, test_reg};
         radio_pkg::RB_TIME:      o_rb_data = i_vita_time;
         radio_pkg::RB_TIME_PPS:  o_rb_data = i_vita_time_pps;
         radio_pkg::RB_RADIO:     o_rb_data = {i_tx, i_rx};
         radio_pkg::RB_RX_STATUS: o_rb_data = {32'd0, i_ovf_count, 15'd0, i_rx_state};
         default:                 o_rb_data = '0;
      endcase
   end

endmodule

/* hw/timekeeper.sv */
// 64-bit time counter with immediate or pps-aligned load
// i_pps is taken as already synchronous to bus_clk
// Write the high word first; the low word write triggers the load
`timescale 1ns/1ps

module timekeeper (
   input  logic                                 bus_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0]     i_set_addr,
   input  logic [radio_pkg::SET_DATA_W-1:0]     i_set_data,
   input  logic                                 i_pps,
   output logic [radio_pkg::WORD_W-1:0]         o_vita_time,
   output logic [radio_pkg::WORD_W-1:0]         o_vita_time_pps
);

   logic [radio_pkg::SET_DATA_W-1:0] time_hi;
   logic [radio_pkg::WORD_W-1:0]     load_val;
   logic                             load_at_pps;
   logic                             armed;      // Load waiting for pps
   logic                             pps_d;
   logic                             pps_rise;
   logic                             wr_lo;

   assign pps_rise = i_pps && !pps_d;
   assign wr_lo    = i_set_stb && (i_set_addr == radio_pkg::SR_TIME_LO);

   always_ff @(posedge bus_clk) begin
      if (i_set_stb && (i_set_addr == radio_pkg::SR_TIME_HI)) time_hi <= i_set_data;
      if (wr_lo) load_val <= {time_hi, i_set_data};
   end

   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
         load_at_pps     <= 1'b0;
         armed           <= 1'b0;
         pps_d           <= 1'b0;
      end else begin
         pps_d <= i_pps;
         if (i_set_stb && (i_set_addr == radio_pkg::SR_TIME_CTRL))
            load_at_pps <= i_set_data[0];

         if (wr_lo && !load_at_pps)
            o_vita_time <= {time_hi, i_set_data};
         else if (pps_rise && armed)
            o_vita_time <= load_val;
         else
            o_vita_time <= o_vita_time + 1'b1;

         // Latch the time that the pps edge marks
         if (pps_rise) o_vita_time_pps <= armed ? load_val : o_vita_time;

         if (wr_lo && load_at_pps) armed <= 1'b1;
         else if (pps_rise) armed <= 1'b0;
      end
   end

endmodule

/* hw/tx_frontend.sv */
// Registered radio TX output, one cycle after the sample
// Holds the last sample when none is valid, idle word while stopped
`timescale 1ns/1ps

module tx_frontend (
   input  logic                                 bus_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_run_tx,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_tx_idle,
   input  logic                                 i_tx_sample_valid,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_tx_sample,
   output logic [radio_pkg::SAMPLE_W-1:0]       o_tx
);

   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_tx <= '0;
      end else if (!i_run_tx) begin
         o_tx <= i_tx_idle;                   // Codec idle while stopped
      end else if (i_tx_sample_valid) begin
         o_tx <= i_tx_sample;
      end
   end

endmodule

/* hw/rx_framer.sv */
// Packs RX sample pairs into 64-bit words and sends them under credits
// First sample goes in the upper half; a half word is lost on stop
// Words arriving at a full buffer are dropped and counted, saturating
`timescale 1ns/1ps

module rx_framer (
   input  logic                                 bus_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_run_rx,
   input  logic                                 i_loopback,
   input  logic [radio_pkg::PKT_W-1:0]          i_pkt_words,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_rx,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_tx,
   input  logic                                 i_rx_credit,
   output logic                                 o_rx_valid,
   output logic [radio_pkg::WORD_W-1:0]         o_rx_data,
   output logic                                 o_rx_last,
   output logic [radio_pkg::OVF_W-1:0]          o_ovf_count,
   output radio_pkg::rx_state_e                 o_rx_state
);

   logic [radio_pkg::SAMPLE_W-1:0] sample;
   logic [radio_pkg::SAMPLE_W-1:0] upper;
   radio_pkg::rx_state_e           state;
   logic [radio_pkg::WORD_W-1:0]   buf_mem [radio_pkg::RX_BUF_DEPTH];
   logic [radio_pkg::RX_PTR_W-1:0] wr_ptr;
   logic [radio_pkg::RX_PTR_W-1:0] rd_ptr;
   logic [radio_pkg::RX_PTR_W:0]   buf_cnt;
   logic [radio_pkg::CRED_W-1:0]   rx_cred;
   logic [radio_pkg::PKT_W-1:0]    pkt_cnt;
   logic                           push;
   logic                           full;
   logic                           wr_en;

   assign sample     = i_loopback ? i_tx : i_rx;           // Digital loopback
   assign push       = i_run_rx && (state == radio_pkg::RX_HALF);
   assign full       = (buf_cnt == radio_pkg::RX_BUF_DEPTH);
   assign wr_en      = push && !full;
   assign o_rx_valid = (buf_cnt != '0) && (rx_cred != '0);
   assign o_rx_data  = buf_mem[rd_ptr];
   assign o_rx_last  = o_rx_valid && (pkt_cnt >= i_pkt_words - 1'b1);
   assign o_rx_state = state;

   always_ff @(posedge bus_clk) begin
      if (i_run_rx && (state == radio_pkg::RX_EMPTY)) upper <= sample;
      if (wr_en) buf_mem[wr_ptr] <= {upper, sample};
   end

   ////////////////////
   // Sample pairing
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         state <= radio_pkg::RX_EMPTY;
      else if (!i_run_rx)
         state <= radio_pkg::RX_EMPTY;        // Drop any held half
      else if (state == radio_pkg::RX_EMPTY)
         state <= radio_pkg::RX_HALF;
      else
         state <= radio_pkg::RX_EMPTY;
   end

   ////////////////////
   // Buffer, credits, packet count, overflow
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         buf_cnt     <= '0;
         rx_cred     <= '0;
         pkt_cnt     <= '0;
         o_ovf_count <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (o_rx_valid) rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !o_rx_valid) buf_cnt <= buf_cnt + 1'b1;
         else if (!wr_en && o_rx_valid) buf_cnt <= buf_cnt - 1'b1;
         if (i_rx_credit && !o_rx_valid) rx_cred <= rx_cred + 1'b1;
         else if (!i_rx_credit && o_rx_valid) rx_cred <= rx_cred - 1'b1;
         if (o_rx_valid) pkt_cnt <= o_rx_last ? '0 : pkt_cnt + 1'b1;
         if (push && full && (o_ovf_count != '1))
            o_ovf_count <= o_ovf_count + 1'b1;
      end
   end

endmodule

/* hw/radio_core.sv */
// Radio top level on one bus_clk with the control decoder, settings,
// timekeeper, TX front end and RX framer
`timescale 1ns/1ps

module radio_core (
   input  logic                                 bus_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_ctrl_valid,
   input  logic [radio_pkg::WORD_W-1:0]         i_ctrl_data,
   input  logic                                 i_resp_credit,
   input  logic                                 i_pps,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_rx,
   input  logic                                 i_tx_sample_valid,
   input  logic [radio_pkg::SAMPLE_W-1:0]       i_tx_sample,
   input  logic                                 i_rx_credit,
   output logic                                 o_ctrl_credit,
   output logic                                 o_resp_valid,
   output logic [radio_pkg::WORD_W-1:0]         o_resp_data,
   output logic [radio_pkg::SAMPLE_W-1:0]       o_tx,
   output logic                                 o_rx_valid,
   output logic [radio_pkg::WORD_W-1:0]         o_rx_data,
   output logic                                 o_rx_last
);

   logic                             set_stb;
   logic [radio_pkg::SET_ADDR_W-1:0] set_addr;
   logic [radio_pkg::SET_DATA_W-1:0] set_data;
   logic [radio_pkg::RB_IDX_W-1:0]   rb_idx;
   logic [radio_pkg::WORD_W-1:0]     rb_data;
   logic [radio_pkg::WORD_W-1:0]     vita_time;
   logic [radio_pkg::WORD_W-1:0]     vita_time_pps;
   logic                             loopback;
   logic                             run_tx;
   logic                             run_rx;
   logic [radio_pkg::SAMPLE_W-1:0]   tx_idle;
   logic [radio_pkg::PKT_W-1:0]      pkt_words;
   logic [radio_pkg::OVF_W-1:0]      ovf_count;
   radio_pkg::rx_state_e             rx_state;

   ////////////////////
   // Control plane
   ctrl_cmd_decoder u_ctrl_cmd_decoder (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_ctrl_valid(i_ctrl_valid), .i_ctrl_data(i_ctrl_data),
      .i_resp_credit(i_resp_credit), .i_rb_data(rb_data),
      .o_ctrl_credit(o_ctrl_credit), .o_resp_valid(o_resp_valid),
      .o_resp_data(o_resp_data), .o_set_stb(set_stb),
      .o_set_addr(set_addr), .o_set_data(set_data), .o_rb_idx(rb_idx)
   );

   radio_settings u_radio_settings (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_rb_idx(rb_idx), .i_vita_time(vita_time), .i_vita_time_pps(vita_time_pps),
      .i_tx(o_tx), .i_rx(i_rx), .i_ovf_count(ovf_count), .i_rx_state(rx_state),
      .o_rb_data(rb_data), .o_loopback(loopback), .o_run_tx(run_tx),
      .o_run_rx(run_rx), .o_tx_idle(tx_idle), .o_pkt_words(pkt_words)
   );

   timekeeper u_timekeeper (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_pps(i_pps), .o_vita_time(vita_time), .o_vita_time_pps(vita_time_pps)
   );

   ////////////////////
   // Sample path
   tx_frontend u_tx_frontend (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_run_tx(run_tx), .i_tx_idle(tx_idle),
      .i_tx_sample_valid(i_tx_sample_valid), .i_tx_sample(i_tx_sample),
      .o_tx(o_tx)
   );

   rx_framer u_rx_framer (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_run_rx(run_rx), .i_loopback(loopback), .i_pkt_words(pkt_words),
      .i_rx(i_rx), .i_tx(o_tx), .i_rx_credit(i_rx_credit),
      .o_rx_valid(o_rx_valid), .o_rx_data(o_rx_data), .o_rx_last(o_rx_last),
      .o_ovf_count(ovf_count), .o_rx_state(rx_state)
   );

endmodule

/* testbench/tb_radio_model.svh */
// Host-side model of the radio settings and of both credit counts
// Included inside tb_radio_core and uses its signals and cycle counter
// Commands go out on the falling edge, responses are sampled there too
`ifndef TB_RADIO_MODEL_SVH
`define TB_RADIO_MODEL_SVH

////////////////////
// Mirrored state
logic [31:0] m_test;
logic [31:0] m_idle;
logic        m_loopback;
logic        m_run_tx;
logic        m_run_rx;
logic [7:0]  m_pkt_len;
int          ctrl_credits;   // Command credits the host holds
int          resp_credits;   // Response credits granted, not yet answered
int          error_count;

task automatic abort_run();
   error_count++;
   $display("TEST FAILED");
   $fatal(1);
endtask

task automatic report_error(input string what);
   $display("Error at cycle %0d: %s", cyc, what);
   abort_run();
endtask

task automatic compare_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
   if (got !== exp) begin
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

function automatic logic [63:0] cmd_word(input logic [7:0] op, input logic [7:0] addr,
                                         input logic [31:0] data);
   return {op, addr, 16'd0, data};
endfunction

// Value itself when inside [lo, hi], else the bound it crossed
function automatic logic [63:0] nearest_in_range(input logic [63:0] v,
                                                 input logic [63:0] lo,
                                                 input logic [63:0] hi);
   if (v < lo) return lo;
   if (v > hi) return hi;
   return v;
endfunction

task automatic update_model(input logic [7:0] addr, input logic [31:0] data);
   case (addr)
      radio_pkg::SR_TEST:       m_test     = data;
      radio_pkg::SR_CODEC_IDLE: m_idle     = data;
      radio_pkg::SR_LOOPBACK:   m_loopback = data[0];
      radio_pkg::SR_TX_CTRL:    m_run_tx   = data[0];
      radio_pkg::SR_RX_CTRL: begin
         m_run_rx  = data[0];
         m_pkt_len = data[15:8];
      end
      default: ;
   endcase
endtask

////////////////////
// Command helpers
task automatic send_word(input logic [7:0] op, input logic [7:0] addr,
                         input logic [31:0] data);
   if (ctrl_credits == 0) report_error("command sent while holding no command credit");
   @(negedge bus_clk);
   i_ctrl_valid = 1'b1;
   i_ctrl_data  = cmd_word(op, addr, data);
   ctrl_credits--;
   @(negedge bus_clk);
   i_ctrl_valid = 1'b0;
endtask

// Grants one response credit, then waits for the response
task automatic take_response(output logic [63:0] resp);
   int waited;
   @(negedge bus_clk);
   i_resp_credit = 1'b1;
   resp_credits++;
   @(negedge bus_clk);
   i_resp_credit = 1'b0;
   waited = 0;
   while (!o_resp_valid) begin
      if (waited == RESP_WAIT) report_error("no response arrived for a pending command");
      @(negedge bus_clk);
      waited++;
   end
   resp = o_resp_data;
   if (!o_ctrl_credit) report_error("command credit did not return with the response");
   ctrl_credits++;
endtask

task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
   logic [63:0] resp;
   send_word(radio_pkg::CMD_WRITE, addr, data);
   take_response(resp);
   compare_value("o_resp_data", resp, cmd_word(radio_pkg::CMD_WRITE, addr, data));
   update_model(addr, data);
endtask

task automatic read_back(input logic [2:0] idx, output logic [63:0] val);
   send_word(radio_pkg::CMD_READ, {5'd0, idx}, 32'd0);
   take_response(val);
endtask

`endif

/* testbench/tb_radio_core.sv */
// Self-checking testbench for radio_core, all on bus_clk
// Inputs change on the falling edge; i_rx counts up once per cycle
// The first error or the cycle limit ends the run
`timescale 1ns/1ps

module tb_radio_core;

   localparam int RESP_WAIT   = 8;
   // Rough phase lengths in cycles
   localparam int PH_RESET    = 10;
   localparam int PH_SETTINGS = 200;
   localparam int PH_TIME     = 100;
   localparam int PH_TX       = 80;
   localparam int PH_OVERFLOW = 100;
   localparam int PH_FRAMING  = 4 * 70;
   localparam int PH_LOOPBACK = 80;
   localparam int CYCLE_LIMIT = 2 * (PH_RESET + PH_SETTINGS + PH_TIME + PH_TX
                                     + PH_OVERFLOW + PH_FRAMING + PH_LOOPBACK);

   logic        bus_clk;
   logic        i_rst_n;
   logic        i_ctrl_valid;
   logic [63:0] i_ctrl_data;
   logic        i_resp_credit;
   logic        i_pps;
   logic [31:0] i_rx;
   logic        i_tx_sample_valid;
   logic [31:0] i_tx_sample;
   logic        i_rx_credit;
   logic        o_ctrl_credit;
   logic        o_resp_valid;
   logic [63:0] o_resp_data;
   logic [31:0] o_tx;
   logic        o_rx_valid;
   logic [63:0] o_rx_data;
   logic        o_rx_last;
   int          cyc;
   logic        rx_loop_mode;    // Expect idle words instead of counter pairs
   logic        rx_first;        // Next word starts a run
   logic [31:0] rx_prev_upper;
   int          rx_words;
   int          rx_since_last;

   `include "tb_radio_model.svh"

   radio_core DUT (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_ctrl_valid(i_ctrl_valid), .i_ctrl_data(i_ctrl_data),
      .i_resp_credit(i_resp_credit), .i_pps(i_pps), .i_rx(i_rx),
      .i_tx_sample_valid(i_tx_sample_valid), .i_tx_sample(i_tx_sample),
      .i_rx_credit(i_rx_credit), .o_ctrl_credit(o_ctrl_credit),
      .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data), .o_tx(o_tx),
      .o_rx_valid(o_rx_valid), .o_rx_data(o_rx_data), .o_rx_last(o_rx_last)
   );

   always #10 bus_clk = ~bus_clk;

   always @(posedge bus_clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) report_error("cycle limit reached before the tests finished");
   end

   always @(negedge bus_clk) begin
      if (i_rst_n) i_rx <= i_rx + 32'd1;   // Counter pattern on the radio input
   end

   // Each response uses up one granted credit
   always @(negedge bus_clk) begin
      if (o_resp_valid) begin
         if (resp_credits == 0) report_error("response sent without a response credit");
         resp_credits--;
      end
   end

   ////////////////////
   // RX word monitor
   task automatic check_rx_word();
      int pkt;
      pkt = (m_pkt_len == 8'd0) ? 1 : m_pkt_len;
      if (rx_loop_mode) begin
         compare_value("o_rx_data", o_rx_data, {m_idle, m_idle});
      end else begin
         compare_value("o_rx_data lower", o_rx_data[31:0], 32'(o_rx_data[63:32] + 32'd1));
         if (!rx_first)
            compare_value("o_rx_data upper", o_rx_data[63:32], 32'(rx_prev_upper + 32'd2));
      end
      compare_value("o_rx_last", o_rx_last, rx_since_last + 1 >= pkt);
      rx_since_last = (rx_since_last + 1 >= pkt) ? 0 : rx_since_last + 1;
      rx_first      = 1'b0;
      rx_prev_upper = o_rx_data[63:32];
      rx_words++;
   endtask

   always @(negedge bus_clk) begin
      if (o_rx_valid) check_rx_word();
   end

   initial begin : main_seq
      logic [63:0] resp;
      logic [63:0] t_load;
      logic [31:0] data;
      logic [31:0] exp_tx;
      logic        valid;
      logic [31:0] q_data [$];
      int          c_mark;
      int          len;
      bus_clk           = 1'b0;
      i_rst_n           = 1'b0;
      i_ctrl_valid      = 1'b0;
      i_ctrl_data       = '0;
      i_resp_credit     = 1'b0;
      i_pps             = 1'b0;
      i_rx              = '0;
      i_tx_sample_valid = 1'b0;
      i_tx_sample       = '0;
      i_rx_credit       = 1'b0;
      cyc               = 0;
      rx_loop_mode      = 1'b0;
      rx_first          = 1'b1;
      rx_prev_upper     = '0;
      rx_words          = 0;
      rx_since_last     = 0;
      m_test            = '0;
      m_idle            = '0;
      m_loopback        = 1'b0;
      m_run_tx          = 1'b0;
      m_run_rx          = 1'b0;
      m_pkt_len         = '0;
      ctrl_credits      = radio_pkg::CTRL_DEPTH;
      resp_credits      = 0;
      error_count       = 0;
      data = $urandom(32'haa015513);
      repeat (5) @(posedge bus_clk);
      @(negedge bus_clk);
      i_rst_n = 1'b1;
      compare_value("o_ctrl_credit", o_ctrl_credit, 1'b0);
      compare_value("o_resp_valid", o_resp_valid, 1'b0);
      compare_value("o_rx_valid", o_rx_valid, 1'b0);
      compare_value("o_rx_last", o_rx_last, 1'b0);
      compare_value("o_tx", o_tx, 32'd0);

      ////////////////////
      // Settings write and readback
      repeat (8) begin
         data = $urandom;
         send_word(radio_pkg::CMD_WRITE, radio_pkg::SR_TEST, data);
         send_word(radio_pkg::CMD_READ, 8'(radio_pkg::RB_TEST), 32'd0);
         take_response(resp);
         compare_value("o_resp_data", resp,
                       cmd_word(radio_pkg::CMD_WRITE, radio_pkg::SR_TEST, data));
         update_model(radio_pkg::SR_TEST, data);
         take_response(resp);
         compare_value("RB_TEST", resp, {32'd0, m_test});
      end
      repeat (radio_pkg::CTRL_DEPTH) begin
         q_data.push_back($urandom);
         send_word(radio_pkg::CMD_WRITE, radio_pkg::SR_TEST, q_data[$]);
      end
      repeat (6) begin   // No response credits yet, so nothing comes back
         @(negedge bus_clk);
         compare_value("o_ctrl_credit", o_ctrl_credit, 1'b0);
      end
      foreach (q_data[i]) begin
         take_response(resp);
         compare_value("o_resp_data", resp,
                       cmd_word(radio_pkg::CMD_WRITE, radio_pkg::SR_TEST, q_data[i]));
         update_model(radio_pkg::SR_TEST, q_data[i]);
      end
      read_back(radio_pkg::RB_TEST, resp);
      compare_value("RB_TEST", resp, {32'd0, m_test});
      for (int idx = 4; idx < 8; idx++) begin
         if (idx != 5) begin
            read_back(3'(idx), resp);
            compare_value("unused readback", resp, 64'd0);
         end
      end
      send_word(8'h5a, 8'd0, $urandom);   // Unknown opcode
      take_response(resp);
      compare_value("o_resp_data", resp, radio_pkg::ERR_RESP);

      ////////////////////
      // Timekeeper immediate load and load at pps
      write_setting(radio_pkg::SR_TIME_CTRL, 32'd0);
      t_load = {$urandom & 32'h7fff_ffff, $urandom};
      write_setting(radio_pkg::SR_TIME_HI, t_load[63:32]);
      write_setting(radio_pkg::SR_TIME_LO, t_load[31:0]);
      c_mark = cyc;
      repeat ($urandom % 8 + 2) @(negedge bus_clk);
      read_back(radio_pkg::RB_TIME, resp);
      compare_value("RB_TIME", resp, nearest_in_range(resp, t_load, t_load + (cyc - c_mark)));
      write_setting(radio_pkg::SR_TIME_CTRL, 32'd1);
      t_load = t_load + 64'h1_0000_0000;   // Far ahead of the running time
      write_setting(radio_pkg::SR_TIME_HI, t_load[63:32]);
      write_setting(radio_pkg::SR_TIME_LO, t_load[31:0]);
      read_back(radio_pkg::RB_TIME, resp);
      compare_value("RB_TIME", resp, nearest_in_range(resp, 64'd0, t_load - 64'd1));
      @(negedge bus_clk);
      i_pps  = 1'b1;
      c_mark = cyc;
      repeat (3) @(negedge bus_clk);
      i_pps = 1'b0;
      write_setting(radio_pkg::SR_TIME_CTRL, 32'd0);
      read_back(radio_pkg::RB_TIME_PPS, resp);
      compare_value("RB_TIME_PPS", resp,
                    nearest_in_range(resp, t_load, t_load + (cyc - c_mark)));
      read_back(radio_pkg::RB_TIME, resp);
      compare_value("RB_TIME", resp, nearest_in_range(resp, t_load, t_load + (cyc - c_mark)));

      ////////////////////
      // TX front end
      write_setting(radio_pkg::SR_CODEC_IDLE, $urandom);
      repeat (2) @(negedge bus_clk);
      compare_value("o_tx", o_tx, m_idle);
      write_setting(radio_pkg::SR_TX_CTRL, 32'd1);
      @(negedge bus_clk);
      exp_tx = m_idle;
      repeat (40) begin
         compare_value("o_tx", o_tx, exp_tx);
         valid             = $urandom % 2;
         data              = $urandom;
         i_tx_sample_valid = valid;
         i_tx_sample       = data;
         if (valid) exp_tx = data;
         @(negedge bus_clk);
      end
      compare_value("o_tx", o_tx, exp_tx);
      i_tx_sample_valid = 1'b0;
      write_setting(radio_pkg::SR_TX_CTRL, 32'd0);

      ////////////////////
      // RX overflow with no credits and packet length 0
      write_setting(radio_pkg::SR_RX_CTRL, 32'd1);
      repeat (4 * radio_pkg::RX_BUF_DEPTH) begin
         @(negedge bus_clk);
         compare_value("o_rx_valid", o_rx_valid, 1'b0);
      end
      write_setting(radio_pkg::SR_RX_CTRL, 32'd0);
      repeat (4) @(negedge bus_clk);
      compare_value("RX words without credits", rx_words, 0);
      i_rx_credit = 1'b1;
      repeat (radio_pkg::RX_BUF_DEPTH + 4) @(negedge bus_clk);
      i_rx_credit = 1'b0;
      repeat (6) @(negedge bus_clk);
      compare_value("RX words after overflow", rx_words, radio_pkg::RX_BUF_DEPTH);
      read_back(radio_pkg::RB_RX_STATUS, resp);
      compare_value("RB_RX_STATUS ovf", resp[31:16], nearest_in_range(resp[31:16], 1, 16'hffff));
      compare_value("RB_RX_STATUS state", resp[0], 1'b0);

      ////////////////////
      // RX framing with a credit every cycle
      i_rx_credit = 1'b1;
      repeat (4) begin
         len      = $urandom % 9;
         rx_first = 1'b1;
         rx_words = 0;
         write_setting(radio_pkg::SR_RX_CTRL, {16'd0, len[7:0], 8'd1});
         repeat (60) @(negedge bus_clk);
         write_setting(radio_pkg::SR_RX_CTRL, {16'd0, len[7:0], 8'd0});
         repeat (6) @(negedge bus_clk);
         compare_value("RX words in run", rx_words, nearest_in_range(rx_words, 25, 64));
      end

      // Loopback of the idle word
      write_setting(radio_pkg::SR_CODEC_IDLE, $urandom);
      write_setting(radio_pkg::SR_LOOPBACK, 32'd1);
      rx_loop_mode = 1'b1;
      rx_words     = 0;
      write_setting(radio_pkg::SR_RX_CTRL, 32'd1);
      repeat (30) @(negedge bus_clk);
      write_setting(radio_pkg::SR_RX_CTRL, 32'd0);
      repeat (6) @(negedge bus_clk);
      compare_value("RX words in loopback", rx_words, nearest_in_range(rx_words, 12, 64));
      write_setting(radio_pkg::SR_LOOPBACK, 32'd0);
      i_rx_credit = 1'b0;
      repeat (4) @(negedge bus_clk);

      if (error_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* sources.f */
+incdir+testbench
hw/radio_pkg.sv
hw/ctrl_cmd_decoder.sv
hw/radio_settings.sv
hw/timekeeper.sv
hw/tx_frontend.sv
hw/rx_framer.sv
hw/radio_core.sv
testbench/tb_radio_core.sv
